//--- fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

`define FETCH_WIDTH   4      // Instructions per fetch block, equal to LINE_WORDS
`define LINE_WORDS    4      // 32-bit words per cache line
`define ADDR_WIDTH    32
`define INSTR_WIDTH   32
`define MEM_LINES     64     // Power of two, line index wraps
`define FTQ_DEPTH     4      // Power of two

// Derived widths
`define LINE_OFF_W    ($clog2(`LINE_WORDS))
`define LINE_IDX_W    ($clog2(`MEM_LINES))
`define MEM_AW        (`LINE_IDX_W + `LINE_OFF_W)   // Word index into the memory
`define FTQ_PTR_W     ($clog2(`FTQ_DEPTH))

`endif

//--- fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // Fetch address, seen either as a plain byte address or split into
    // line number, word within the line and byte within the word
    typedef union packed {
        logic [`ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [`ADDR_WIDTH-`LINE_OFF_W-3:0] line;
            logic [`LINE_OFF_W-1:0]             word;
            logic [1:0]                         byte_off;  // Always zero for fetch targets
        } f;
    } fetch_addr_u;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,    // Waiting for the first redirect
        STREAM,  // Popping blocks and reading lines
        FLUSH    // One dead cycle after a redirect
    } fetch_state_t;

endpackage

//--- fetch_pc_gen.sv
`include "fetch_settings.svh"

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect_i,
    input  fetch_addr_u redirect_pc_i,
    input  logic        full_i,
    output logic        push_o,
    output fetch_addr_u push_addr_o
);

    // One fetch block worth of bytes
    localparam logic [`ADDR_WIDTH-1:0] BLOCK_BYTES = (`ADDR_WIDTH)'(`FETCH_WIDTH * 4);

    logic        active;  // Set by the first redirect
    fetch_addr_u pc;

    // Redirect cycle pushes nothing, queue is being flushed
    assign push_o      = active && !full_i && !redirect_i;
    assign push_addr_o = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            pc.raw <= '0;
        end else if (redirect_i) begin
            active <= 1'b1;
            pc     <= redirect_pc_i;
        end else if (push_o) begin
            pc.raw <= pc.raw + BLOCK_BYTES;  // Next sequential block
        end
    end

    // Core must redirect to a word boundary
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_i |-> (redirect_pc_i.f.byte_off == 2'b00)
    ) else $error("redirect_pc_i not word aligned");

endmodule

//--- fetch_target_queue.sv
`include "fetch_settings.svh"

module fetch_target_queue
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic        push_i,
    input  fetch_addr_u push_addr_i,
    input  logic        pop_i,
    output fetch_addr_u head_addr_o,
    output logic        empty_o,
    output logic        full_o
);

    localparam logic [`FTQ_PTR_W:0]   DEPTH    = (`FTQ_PTR_W + 1)'(`FTQ_DEPTH);
    localparam logic [`FTQ_PTR_W-1:0] LAST_PTR = (`FTQ_PTR_W)'(`FTQ_DEPTH - 1);

    fetch_addr_u             entries [`FTQ_DEPTH];
    logic [`FTQ_PTR_W-1:0]   wr_ptr;
    logic [`FTQ_PTR_W-1:0]   rd_ptr;
    logic [`FTQ_PTR_W:0]     count;

    function automatic logic [`FTQ_PTR_W-1:0] ptr_inc(input logic [`FTQ_PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o     = (count == '0);
    assign full_o      = (count == DEPTH);
    assign head_addr_o = entries[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;  // Everything in flight is dropped
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or simultaneous push and pop
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            entries[wr_ptr] <= push_addr_i;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o
    ) else $error("FTQ push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o
    ) else $error("FTQ pop while empty");

endmodule

//--- fetch_ctrl.sv
`include "fetch_settings.svh"

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   redirect_i,
    input  logic                   stall_i,
    input  logic                   empty_i,
    input  fetch_addr_u            head_addr_i,
    output logic                   pop_o,
    output logic                   rd_en_o,
    output logic [`LINE_IDX_W-1:0] rd_line0_o,
    output logic [`LINE_IDX_W-1:0] rd_line1_o,
    output logic [`LINE_OFF_W-1:0] s1_word_off_o,
    output fetch_addr_u            s1_pc_o,
    output logic                   out_load_o,
    output logic                   out_clear_o
);

    localparam logic [`LINE_IDX_W-1:0] LAST_LINE = (`LINE_IDX_W)'(`MEM_LINES - 1);

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic         s1_valid;  // Memory read registers hold a live block
    logic         s2_valid;  // Output register holds a live block
    logic         advance;
    logic         kill;

    always_comb begin
        state_nxt = state;
        if (redirect_i) begin
            state_nxt = FLUSH;
        end else begin
            case (state)
                IDLE:    state_nxt = IDLE;
                FLUSH:   state_nxt = STREAM;
                STREAM:  state_nxt = STREAM;
                default: state_nxt = IDLE;
            endcase
        end
    end

    assign kill    = redirect_i || (state == FLUSH);
    assign advance = !s2_valid || !stall_i;  // Output free or being consumed

    assign pop_o   = (state == STREAM) && !redirect_i && !empty_i && advance;
    assign rd_en_o = pop_o;

    // Low line bits equal the line modulo MEM_LINES
    assign rd_line0_o = head_addr_i.f.line[`LINE_IDX_W-1:0];
    assign rd_line1_o = (rd_line0_o == LAST_LINE) ? '0 : rd_line0_o + 1'b1;

    assign out_load_o  = !kill && advance && s1_valid;
    assign out_clear_o = kill || (advance && !s1_valid);

    assign s1_word_off_o = s1_pc_o.f.word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (kill) begin
                s1_valid <= 1'b0;
                s2_valid <= 1'b0;
            end else if (advance) begin
                s1_valid <= pop_o;
                s2_valid <= s1_valid;
            end
        end
    end

    // PC of the block whose lines are in the read registers
    always_ff @(posedge clk) begin
        if (pop_o) begin
            s1_pc_o <= head_addr_i;
        end
    end

    a_load_clear_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(out_load_o && out_clear_o)
    ) else $error("aligner load and clear together");

endmodule

//--- icache_line_mem.sv
`include "fetch_settings.svh"

module icache_line_mem (
    input  logic                                     clk,
    input  logic                                     rd_en_i,
    input  logic [`LINE_IDX_W-1:0]                   rd_line0_i,
    input  logic [`LINE_IDX_W-1:0]                   rd_line1_i,
    output logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0] line0_o,
    output logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0] line1_o,
    input  logic                                     we_i,
    input  logic [`MEM_AW-1:0]                       waddr_i,
    input  logic [`INSTR_WIDTH-1:0]                  wdata_i
);

    logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0] mem [`MEM_LINES];

    logic [`LINE_IDX_W-1:0] w_line;  // Line holding the written word
    logic [`LINE_OFF_W-1:0] w_word;

    assign w_line = waddr_i[`MEM_AW-1:`LINE_OFF_W];
    assign w_word = waddr_i[`LINE_OFF_W-1:0];

    // Loader port, one word per cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[w_line][w_word] <= wdata_i;
        end
    end

    // Two line reads, outputs hold between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            line0_o <= mem[rd_line0_i];
            line1_o <= mem[rd_line1_i];  // Next line for blocks crossing a boundary
        end
    end

endmodule

//--- instr_align.sv
`include "fetch_settings.svh"

module instr_align
    import fetch_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      load_i,
    input  logic                                      clear_i,
    input  logic [`LINE_OFF_W-1:0]                    word_off_i,
    input  fetch_addr_u                               pc_i,
    input  logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0]  line0_i,
    input  logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0]  line1_i,
    output logic                                      valid_o,
    output fetch_addr_u                               pc_o,
    output logic [`FETCH_WIDTH-1:0][`INSTR_WIDTH-1:0] instr_o
);

    logic [2*`LINE_WORDS-1:0][`INSTR_WIDTH-1:0] pair;    // line0 in the low words
    logic [`FETCH_WIDTH-1:0][`INSTR_WIDTH-1:0]  picked;

    assign pair = {line1_i, line0_i};

    // Window of FETCH_WIDTH words starting at the block offset
    always_comb begin
        logic [`LINE_OFF_W:0] idx;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            idx       = (`LINE_OFF_W + 1)'(word_off_i) + (`LINE_OFF_W + 1)'(i);
            picked[i] = pair[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= 1'b1;
        end
    end

    // Block payload, held while stalled
    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_o    <= pc_i;
            instr_o <= picked;
        end
    end

endmodule

//--- fetch_top.sv
`include "fetch_settings.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      redirect_i,
    input  fetch_addr_u                               redirect_pc_i,
    input  logic                                      mem_we_i,
    input  logic [`MEM_AW-1:0]                        mem_waddr_i,
    input  logic [`INSTR_WIDTH-1:0]                   mem_wdata_i,
    input  logic                                      stall_i,
    output logic                                      ib_valid_o,
    output fetch_addr_u                               ib_pc_o,
    output logic [`FETCH_WIDTH-1:0][`INSTR_WIDTH-1:0] ib_instr_o
);

    // PC generator to queue
    logic        push;
    fetch_addr_u push_addr;
    logic        full;

    // Queue to controller
    logic        pop;
    logic        empty;
    fetch_addr_u head_addr;

    // Controller to memory and aligner
    logic                   rd_en;
    logic [`LINE_IDX_W-1:0] rd_line0;
    logic [`LINE_IDX_W-1:0] rd_line1;
    logic [`LINE_OFF_W-1:0] s1_word_off;
    fetch_addr_u            s1_pc;
    logic                   out_load;
    logic                   out_clear;

    logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0] line0;
    logic [`LINE_WORDS-1:0][`INSTR_WIDTH-1:0] line1;

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .full_i        (full),
        .push_o        (push),
        .push_addr_o   (push_addr)
    );

    fetch_target_queue u_ftq (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (redirect_i),
        .push_i      (push),
        .push_addr_i (push_addr),
        .pop_i       (pop),
        .head_addr_o (head_addr),
        .empty_o     (empty),
        .full_o      (full)
    );

    fetch_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect_i),
        .stall_i       (stall_i),
        .empty_i       (empty),
        .head_addr_i   (head_addr),
        .pop_o         (pop),
        .rd_en_o       (rd_en),
        .rd_line0_o    (rd_line0),
        .rd_line1_o    (rd_line1),
        .s1_word_off_o (s1_word_off),
        .s1_pc_o       (s1_pc),
        .out_load_o    (out_load),
        .out_clear_o   (out_clear)
    );

    icache_line_mem u_mem (
        .clk        (clk),
        .rd_en_i    (rd_en),
        .rd_line0_i (rd_line0),
        .rd_line1_i (rd_line1),
        .line0_o    (line0),
        .line1_o    (line1),
        .we_i       (mem_we_i),
        .waddr_i    (mem_waddr_i),
        .wdata_i    (mem_wdata_i)
    );

    instr_align u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_i     (out_load),
        .clear_i    (out_clear),
        .word_off_i (s1_word_off),
        .pc_i       (s1_pc),
        .line0_i    (line0),
        .line1_i    (line1),
        .valid_o    (ib_valid_o),
        .pc_o       (ib_pc_o),
        .instr_o    (ib_instr_o)
    );

endmodule

//--- tb_fetch_top.sv
`include "fetch_settings.svh"

module tb_fetch_top
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`FETCH_WIDTH-1:0][`INSTR_WIDTH-1:0] block_words_t;

    localparam int MEM_WORDS       = `MEM_LINES * `LINE_WORDS;
    localparam int RESET_CYCLES    = 8;
    localparam int IDLE_CYCLES     = 20;
    localparam int ALIGNED_CYCLES  = 40;
    localparam int OFFSET_CYCLES   = 20;
    localparam int STALL_CYCLES    = 200;
    localparam int MID_CYCLES      = 40;
    localparam int LONG_CYCLES     = 1200;
    localparam int DRAIN_CYCLES    = 10;
    localparam int REDIRECTS       = 12;   // Directed redirects, two cycles each
    localparam int MIN_LONG_BLOCKS = 300;
    localparam int TEST_CYCLES     = RESET_CYCLES + IDLE_CYCLES + MEM_WORDS + 1
                                   + 2 * ALIGNED_CYCLES + 6 * OFFSET_CYCLES + STALL_CYCLES
                                   + MID_CYCLES + LONG_CYCLES + DRAIN_CYCLES + 2 * REDIRECTS;
    localparam logic [`ADDR_WIDTH-1:0] BLOCK_BYTES = `FETCH_WIDTH * 4;

    logic                    clk;
    logic                    rst_n;
    logic                    redirect_i;
    fetch_addr_u             redirect_pc_i;
    logic                    mem_we_i;
    logic [`MEM_AW-1:0]      mem_waddr_i;
    logic [`INSTR_WIDTH-1:0] mem_wdata_i;
    logic                    stall_i;
    logic                    ib_valid_o;
    fetch_addr_u             ib_pc_o;
    block_words_t            ib_instr_o;

    logic [`INSTR_WIDTH-1:0] image [MEM_WORDS];  // Copy of what the loader wrote
    int                      seed;

    // Monitor state
    fetch_addr_u  exp_pc;
    fetch_addr_u  prev_pc;
    block_words_t prev_instr;
    logic         started        = 1'b0;
    logic         prev_hold      = 1'b0;  // Last cycle showed a stalled block
    logic         after_redirect = 1'b0;
    int           blocks         = 0;
    int           checks         = 0;
    int           errors_flag    = 0;
    int           errors_pc      = 0;
    int           errors_instr   = 0;
    int           errors_other   = 0;
    int           long_start;

    fetch_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .mem_we_i      (mem_we_i),
        .mem_waddr_i   (mem_waddr_i),
        .mem_wdata_i   (mem_wdata_i),
        .stall_i       (stall_i),
        .ib_valid_o    (ib_valid_o),
        .ib_pc_o       (ib_pc_o),
        .ib_instr_o    (ib_instr_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Words a block starting at this PC must carry
    function automatic block_words_t expected_words(input fetch_addr_u start);
        block_words_t       words;
        logic [`MEM_AW-1:0] w;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            w = (`MEM_AW)'((start.raw >> 2) + 32'(i));  // Wraps at the end of memory
            words[i] = image[w];
        end
        return words;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors_flag++;
            $display("ERROR at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input fetch_addr_u got, input fetch_addr_u exp, input string what);
        checks++;
        if (got !== exp) begin
            errors_pc++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic check_instr(input block_words_t got, input block_words_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors_instr++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_memory();
        logic [`INSTR_WIDTH-1:0] data;
        logic [`MEM_AW-1:0]      addr;
        for (int w = 0; w < MEM_WORDS; w++) begin
            @(posedge clk);
            addr        = (`MEM_AW)'(w);
            data        = $random(seed);
            image[addr] = data;
            mem_we_i    <= 1'b1;
            mem_waddr_i <= addr;
            mem_wdata_i <= data;
        end
        @(posedge clk);
        mem_we_i <= 1'b0;
    endtask

    task automatic redirect_to(input logic [`ADDR_WIDTH-1:0] pc);
        @(posedge clk);
        redirect_i        <= 1'b1;
        redirect_pc_i.raw <= pc;
        @(posedge clk);
        redirect_i <= 1'b0;
    endtask

    // Random stall levels and single-cycle redirects, rates in percent
    task automatic run_cycles(input int n, input int unsigned stall_pct,
                              input int unsigned redir_pct);
        fetch_addr_u pc;
        logic        redir;
        redir = 1'b0;
        repeat (n) begin
            @(posedge clk);
            pc.raw        = $random(seed);
            pc.f.byte_off = 2'b00;
            redir         = !redir && (rand_below(100) < redir_pct);  // No back-to-back pulses
            stall_i       <= (rand_below(100) < stall_pct);
            redirect_i    <= redir;
            redirect_pc_i <= pc;
        end
    endtask

    // Inputs settle before the falling edge, so all sampling happens there
    always @(negedge clk) begin
        if (rst_n) begin
            if (!started || after_redirect) begin
                check_flag(ib_valid_o, 1'b0, "ib_valid_o with no block allowed");
            end
            if (prev_hold) begin
                check_flag(ib_valid_o, 1'b1, "ib_valid_o dropped under stall");
                check_pc(ib_pc_o, prev_pc, "ib_pc_o changed under stall");
                check_instr(ib_instr_o, prev_instr, "ib_instr_o changed under stall");
            end
            if (ib_valid_o) begin
                check_pc(ib_pc_o, exp_pc, "block PC");
                check_instr(ib_instr_o, expected_words(exp_pc), "block words");
                if (!stall_i) begin
                    exp_pc.raw = exp_pc.raw + BLOCK_BYTES;  // Consumed at the next edge
                    blocks++;
                end
            end
            prev_hold      = ib_valid_o && stall_i && !redirect_i;
            prev_pc        = ib_pc_o;
            prev_instr     = ib_instr_o;
            after_redirect = redirect_i;
            if (redirect_i) begin
                started = 1'b1;
                exp_pc  = redirect_pc_i;  // Old stream is dead from here on
            end
        end
    end

    initial begin
        repeat (TEST_CYCLES * 4) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES * 4);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed          = 68020;
        rst_n         = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        mem_we_i      = 1'b0;
        mem_waddr_i   = '0;
        mem_wdata_i   = '0;
        stall_i       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        run_cycles(IDLE_CYCLES, 0, 0);  // Fetch must stay quiet until redirected
        load_memory();

        redirect_to(32'h0000_0000);
        run_cycles(ALIGNED_CYCLES, 0, 0);
        redirect_to(32'h0000_03C0);     // Runs off line 63 back to line 0
        run_cycles(ALIGNED_CYCLES, 0, 0);

        for (int off = 1; off < 4; off++) begin
            redirect_to(32'h0000_0050 + 4 * off);
            run_cycles(OFFSET_CYCLES, 0, 0);
            redirect_to(32'h0001_03F0 + 4 * off);  // Last line, second line is line 0
            run_cycles(OFFSET_CYCLES, 0, 0);
        end

        redirect_to(32'h0000_0100);
        run_cycles(STALL_CYCLES, 50, 0);

        // Mid-stream redirects, one of them while the output is stalled
        redirect_to(32'h0000_0040);
        run_cycles(MID_CYCLES / 4, 0, 0);
        redirect_to(32'h0000_0208);
        run_cycles(MID_CYCLES / 4, 100, 0);
        redirect_to(32'h0000_02F4);
        run_cycles(MID_CYCLES / 2, 0, 0);

        long_start = blocks;
        run_cycles(LONG_CYCLES, 30, 3);
        run_cycles(DRAIN_CYCLES, 0, 0);

        if (blocks - long_start < MIN_LONG_BLOCKS) begin
            errors_other++;
            $display("Long random run delivered only %0d blocks, at least %0d needed",
                     blocks - long_start, MIN_LONG_BLOCKS);
        end
        $display("Checks %0d, blocks %0d, errors: valid %0d, pc %0d, instr %0d, other %0d",
                 checks, blocks, errors_flag, errors_pc, errors_instr, errors_other);
        if (errors_flag + errors_pc + errors_instr + errors_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
fetch_target_queue.sv
fetch_ctrl.sv
icache_line_mem.sv
instr_align.sv
fetch_top.sv
tb_fetch_top.sv

//--- Makefile
TOP := tb_fetch_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)
	verilator --lint-only -Wall --timing +incdir+. fetch_pkg.sv fetch_pc_gen.sv \
		fetch_target_queue.sv fetch_ctrl.sv icache_line_mem.sv instr_align.sv \
		fetch_top.sv --top-module fetch_top

clean:
	rm -rf obj_dir $(LOG)
